// File: common/regstat_defines.svh
`ifndef REGSTAT_DEFINES_SVH
`define REGSTAT_DEFINES_SVH

// ==============================
// core sizing
// ==============================

// number of architectural registers tracked by the valid and source tables
`define AREGS 64

// depth of the circular issue queue
`define QENTRIES 8

// width of a queue tag, enough to name every queue entry
`define TAG_W 3

// ==============================
// fixed register numbers
// ==============================

// a linking back branch writes its return address here
`define LR0 56

`endif

// File: common/regstat_pkg.sv
`default_nettype none
`include "regstat_defines.svh"

package regstat_pkg;

	// ==============================
	// register and tag types
	// ==============================

	// architectural register number
	typedef logic [$clog2(`AREGS)-1:0] regspec_t;

	// names one issue queue entry
	typedef logic [`TAG_W-1:0] qtag_t;

	// one decoded instruction as it comes out of fetch
	typedef struct packed {
		logic v;
		logic rfw;
		regspec_t tgt;
		logic back_branch;
		logic lk;
	} fetch_slot_t;

	// what the queue keeps per entry for register bookkeeping
	typedef struct packed {
		logic v;
		logic rfw;
		regspec_t tgt;
	} iq_entry_t;

	// one retirement, v is set only when the entry writes a register
	typedef struct packed {
		logic v;
		regspec_t tgt;
		qtag_t id;
	} commit_t;

	// queue occupancy, needed because head equal to tail is ambiguous
	typedef enum logic [1:0] {
		EMPTY,
		PARTIAL,
		FULL
	} iq_state_e;

	// ==============================
	// slot helpers
	// ==============================

	// a slot writes a register if it says so, or if it is a linking back branch
	function automatic logic slot_writes(fetch_slot_t s);
		return s.rfw || (s.back_branch && s.lk);
	endfunction

	// a linking back branch always lands in the link register
	function automatic regspec_t slot_dest(fetch_slot_t s);
		return (s.back_branch && s.lk) ? regspec_t'(`LR0) : s.tgt;
	endfunction

endpackage

`default_nettype wire

// File: hw/issue_queue.sv
`timescale 1ns/10ps
`default_nettype none
`include "regstat_defines.svh"

module issue_queue (
	input wire logic clk,
	input wire logic rst,
	input wire regstat_pkg::fetch_slot_t slot0,
	input wire regstat_pkg::fetch_slot_t slot1,
	input wire logic commit_en,
	input wire logic branchmiss,
	input wire regstat_pkg::qtag_t miss_id,
	input wire regstat_pkg::qtag_t [`AREGS-1:0] rf_source,
	output regstat_pkg::qtag_t tail0,
	output regstat_pkg::qtag_t tail1,
	output logic enq0,
	output logic enq1,
	output regstat_pkg::commit_t commit0,
	output regstat_pkg::commit_t commit1,
	output logic [`AREGS-1:0] livetarget,
	output logic [`QENTRIES-1:0] iqentry_source,
	output logic [1:0] enq_count,
	output regstat_pkg::iq_state_e iq_state
);
	import regstat_pkg::*;

	iq_entry_t [`QENTRIES-1:0] iq;
	iq_entry_t [`QENTRIES-1:0] iq_n;
	logic [`QENTRIES-1:0] iq_v;
	logic [`QENTRIES-1:0] iq_v_n;
	logic [`QENTRIES-1:0] flush_m;
	qtag_t head0;
	qtag_t head1;
	qtag_t head_n;
	qtag_t tail_n;
	qtag_t miss_next;
	qtag_t flush_span;
	qtag_t occupancy;
	iq_state_e state_n;
	logic take0;
	logic take1;
	logic lone1;
	logic ret0;
	logic ret1;

	// builds the queue record of a slot, a linking branch becomes a write to the link register
	function automatic iq_entry_t make_entry(fetch_slot_t s);
		iq_entry_t e;
		e.v = 1'b1;
		e.rfw = slot_writes(s);
		e.tgt = slot_dest(s);
		return e;
	endfunction

	assign head1 = head0 + qtag_t'(1);
	assign tail1 = tail0 + qtag_t'(1);

	// ==============================
	// enqueue
	// ==============================

	// slot0 needs only a free entry at the tail
	assign take0 = !branchmiss && slot0.v && !iq[tail0].v;
	// a back branch ends the fetch group so slot1 waits for the next cycle
	assign take1 = take0 && !slot0.back_branch && slot1.v && !iq[tail1].v;
	// a lone slot1 goes into the tail0 entry
	assign lone1 = !branchmiss && !slot0.v && slot1.v && !iq[tail0].v;

	assign enq0 = take0;
	assign enq1 = take1 || lone1;
	assign enq_count = {1'b0, enq0} + {1'b0, enq1};

	// ==============================
	// flush and commit
	// ==============================

	// everything from the entry after the missed branch up to the tail is squashed
	assign miss_next = miss_id + qtag_t'(1);
	assign flush_span = tail0 - miss_next;

	always_comb begin
		for (int i = 0; i < `QENTRIES; i++) begin
			flush_m[i] = branchmiss && iq[i].v &&
				(qtag_t'(qtag_t'(i) - miss_next) < flush_span);
		end
	end

	// retire in order, the second entry only behind the first
	assign ret0 = commit_en && iq[head0].v && !flush_m[head0];
	assign ret1 = ret0 && iq[head1].v && !flush_m[head1];

	assign commit0 = '{v: ret0 && iq[head0].rfw, tgt: iq[head0].tgt, id: head0};
	assign commit1 = '{v: ret1 && iq[head1].rfw, tgt: iq[head1].tgt, id: head1};

	// survivors of a flush this cycle still hold their target pending
	always_comb begin
		livetarget = '0;
		iqentry_source = '0;
		for (int i = 0; i < `QENTRIES; i++) begin
			iq_v[i] = iq[i].v;
			if (iq[i].v && iq[i].rfw && !flush_m[i])
				livetarget[iq[i].tgt] = 1'b1;
			// an entry is the source when the source table still points at it
			iqentry_source[i] = iq[i].v && iq[i].rfw && (rf_source[iq[i].tgt] == qtag_t'(i));
		end
	end

	// ==============================
	// next state
	// ==============================

	always_comb begin
		iq_n = iq;
		head_n = head0;
		if (ret0) begin
			iq_n[head0].v = 1'b0;
			head_n = head1;
		end
		if (ret1) begin
			iq_n[head1].v = 1'b0;
			head_n = head1 + qtag_t'(1);
		end
		for (int i = 0; i < `QENTRIES; i++) begin
			if (flush_m[i])
				iq_n[i].v = 1'b0;
		end
		// enqueue never overlaps a flush so these writes land only on free entries
		if (take0)
			iq_n[tail0] = make_entry(slot0);
		if (take1)
			iq_n[tail1] = make_entry(slot1);
		if (lone1)
			iq_n[tail0] = make_entry(slot1);
		tail_n = branchmiss ? miss_next : tail0 + qtag_t'(enq_count);
		for (int i = 0; i < `QENTRIES; i++) begin
			iq_v_n[i] = iq_n[i].v;
		end
		// equal pointers mean full or empty, the valid bits tell which
		if (head_n != tail_n)
			state_n = PARTIAL;
		else if (|iq_v_n)
			state_n = FULL;
		else
			state_n = EMPTY;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			iq <= '0;
			head0 <= '0;
			tail0 <= '0;
			iq_state <= EMPTY;
		end else begin
			iq <= iq_n;
			head0 <= head_n;
			tail0 <= tail_n;
			iq_state <= state_n;
		end
	end

	// the valid entries are exactly the run from head up to tail
	assign occupancy = tail0 - head0;

	a_head_tail: assert property (@(posedge clk) disable iff (rst)
		$countones(iq_v) == ((iq_state == FULL) ? `QENTRIES : int'(occupancy)));

endmodule

`default_nettype wire

// File: hw/regfile_source.sv
`timescale 1ns/10ps
`default_nettype none
`include "regstat_defines.svh"

module regfile_source (
	input wire logic clk,
	input wire logic rst,
	input wire regstat_pkg::fetch_slot_t slot0,
	input wire regstat_pkg::fetch_slot_t slot1,
	input wire logic enq0,
	input wire logic enq1,
	input wire regstat_pkg::qtag_t tail0,
	input wire regstat_pkg::qtag_t tail1,
	input wire logic branchmiss,
	output regstat_pkg::qtag_t [`AREGS-1:0] rf_source
);
	import regstat_pkg::*;

	logic wr0;
	logic wr1;
	regspec_t dst0;
	regspec_t dst1;
	qtag_t tag1;

	// ==============================
	// writer decode
	// ==============================

	// a slot only updates the table when it was actually taken into the queue
	assign wr0 = enq0 && slot_writes(slot0);
	assign wr1 = enq1 && slot_writes(slot1);

	// linking back branches are redirected to the link register
	assign dst0 = slot_dest(slot0);
	assign dst1 = slot_dest(slot1);

	// slot1 sits behind slot0 normally
	// when it came alone it took the tail0 entry instead
	assign tag1 = enq0 ? tail1 : tail0;

	// ==============================
	// source table
	// ==============================

	// each register remembers the tag of the youngest entry that will write it
	// the entries are never cleared since the valid tracker decides if a tag still matters
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			rf_source <= '0;
		end else if (!branchmiss) begin
			if (wr0)
				rf_source[dst0] <= tail0;
			// slot1 is younger, so on a shared target its write comes last and wins
			if (wr1)
				rf_source[dst1] <= tag1;
		end
	end

	// a flush cycle leaves the table alone
	// stale tags are harmless because the flushed registers revalidate through livetarget
	// and a reused tag is rewritten by its own enqueue

endmodule

`default_nettype wire

// File: hw/regfile_valid.sv
`timescale 1ns/10ps
`default_nettype none
`include "regstat_defines.svh"

module regfile_valid (
	input wire logic clk,
	input wire logic rst,
	input wire logic branchmiss,
	input wire regstat_pkg::fetch_slot_t slot0,
	input wire regstat_pkg::fetch_slot_t slot1,
	input wire logic enq0,
	input wire logic enq1,
	input wire regstat_pkg::commit_t commit0,
	input wire regstat_pkg::commit_t commit1,
	input wire logic [`AREGS-1:0] livetarget,
	input wire logic [`QENTRIES-1:0] iqentry_source,
	input wire regstat_pkg::qtag_t [`AREGS-1:0] rf_source,
	output logic [`AREGS-1:0] rf_v
);
	import regstat_pkg::*;

	logic [`AREGS-1:0] rf_vr;
	logic wr0;
	logic wr1;
	regspec_t dst0;
	regspec_t dst1;
	logic same_dst;
	logic done0;
	logic done1;

	// ==============================
	// enqueue side
	// ==============================

	assign wr0 = enq0 && slot_writes(slot0);
	assign wr1 = enq1 && slot_writes(slot1);
	assign dst0 = slot_dest(slot0);
	assign dst1 = slot_dest(slot1);

	// when both slots write the same register only the later one counts
	assign same_dst = wr0 && wr1 && (dst0 == dst1);

	// ==============================
	// commit side
	// ==============================

	// a retiring entry finalizes its register only if nothing younger still writes it
	// during a flush the queue's own newest-writer view is trusted as well
	assign done0 = (rf_source[commit0.tgt] == commit0.id) ||
		(branchmiss && iqentry_source[commit0.id]);
	assign done1 = (rf_source[commit1.tgt] == commit1.id) ||
		(branchmiss && iqentry_source[commit1.id]);

	// ==============================
	// valid bits
	// ==============================

	// later assignments in this block take priority
	// so enqueue beats commit and commit beats flush recovery
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			rf_vr <= '1;
		end else begin
			// registers whose pending writers were all squashed become final again
			if (branchmiss) begin
				for (int n = 1; n < `AREGS; n++) begin
					if (!rf_vr[n] && !livetarget[n])
						rf_vr[n] <= 1'b1;
				end
			end

			if (commit0.v && !rf_vr[commit0.tgt])
				rf_vr[commit0.tgt] <= done0;
			// commit1 is younger so its result wins on a shared target
			if (commit1.v && !rf_vr[commit1.tgt])
				rf_vr[commit1.tgt] <= done1;

			// a new pending writer hides the register until it retires
			// r0 never takes a pending writer and keeps reading final
			if (wr0 && !same_dst && dst0 != '0)
				rf_vr[dst0] <= 1'b0;
			if (wr1 && dst1 != '0)
				rf_vr[dst1] <= 1'b0;
		end
	end

	assign rf_v = rf_vr;

	// no enqueue, commit or flush path may ever clear r0
	a_r0_valid: assert property (@(posedge clk) disable iff (rst) rf_v[0]);

endmodule

`default_nettype wire

// File: hw/regstat_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "regstat_defines.svh"

module regstat_top (
	input wire logic clk,
	input wire logic rst,
	input wire regstat_pkg::fetch_slot_t slot0,
	input wire regstat_pkg::fetch_slot_t slot1,
	input wire logic commit_en,
	input wire logic branchmiss,
	input wire regstat_pkg::qtag_t miss_id,
	output logic [`AREGS-1:0] rf_v,
	output logic [1:0] enq_count,
	output regstat_pkg::iq_state_e iq_state
);
	import regstat_pkg::*;

	// ==============================
	// queue to table wiring
	// ==============================

	qtag_t tail0;
	qtag_t tail1;
	logic enq0;
	logic enq1;
	commit_t commit0;
	commit_t commit1;
	logic [`AREGS-1:0] livetarget;
	logic [`QENTRIES-1:0] iqentry_source;
	// the source table feeds both the valid tracker and the queue's newest-writer flags
	qtag_t [`AREGS-1:0] rf_source;

	issue_queue u_queue (
		.clk(clk), .rst(rst),
		.slot0(slot0), .slot1(slot1),
		.commit_en(commit_en), .branchmiss(branchmiss), .miss_id(miss_id),
		.rf_source(rf_source),
		.tail0(tail0), .tail1(tail1), .enq0(enq0), .enq1(enq1),
		.commit0(commit0), .commit1(commit1),
		.livetarget(livetarget), .iqentry_source(iqentry_source),
		.enq_count(enq_count), .iq_state(iq_state)
	);

	regfile_source u_source (
		.clk(clk), .rst(rst),
		.slot0(slot0), .slot1(slot1), .enq0(enq0), .enq1(enq1),
		.tail0(tail0), .tail1(tail1), .branchmiss(branchmiss),
		.rf_source(rf_source)
	);

	regfile_valid u_valid (
		.clk(clk), .rst(rst), .branchmiss(branchmiss),
		.slot0(slot0), .slot1(slot1), .enq0(enq0), .enq1(enq1),
		.commit0(commit0), .commit1(commit1),
		.livetarget(livetarget), .iqentry_source(iqentry_source),
		.rf_source(rf_source), .rf_v(rf_v)
	);

endmodule

`default_nettype wire

// File: testbench/tb_regstat.sv
`timescale 1ns/10ps
`default_nettype none
`include "regstat_defines.svh"

module tb_regstat;
	import regstat_pkg::*;

	// ==============================
	// run length
	// ==============================

	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 5;
	// each sequence fits well inside this many cycles
	localparam int TEST_BUDGET = 64;
	// one spare budget on top of reset and the sequences
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + (NUM_TESTS + 1) * TEST_BUDGET;

	logic clk = 1'b0;
	logic rst;
	fetch_slot_t slot0;
	fetch_slot_t slot1;
	logic commit_en;
	logic branchmiss;
	qtag_t miss_id;
	logic [`AREGS-1:0] rf_v;
	logic [1:0] enq_count;
	iq_state_e iq_state;

	int error_count = 0;
	int tests_run = 0;
	int tests_passed = 0;

	// shadow copy of the queue, the source table and the valid bits
	logic [`QENTRIES-1:0] sq_v;
	logic [`QENTRIES-1:0] sq_rfw;
	regspec_t [`QENTRIES-1:0] sq_tgt;
	qtag_t s_head;
	qtag_t s_tail;
	qtag_t [`AREGS-1:0] s_src;
	logic [`AREGS-1:0] exp_rf_v;
	iq_state_e exp_state;
	logic exp_take0;
	logic exp_take1;
	logic exp_lone;
	logic [1:0] exp_count;

	regstat_top DUT (
		.clk(clk), .rst(rst),
		.slot0(slot0), .slot1(slot1),
		.commit_en(commit_en), .branchmiss(branchmiss), .miss_id(miss_id),
		.rf_v(rf_v), .enq_count(enq_count), .iq_state(iq_state)
	);

	always #50 clk = ~clk;

	// a linking back branch also writes, and it always writes the link register
	function automatic logic is_writer(fetch_slot_t s);
		return s.rfw || (s.back_branch && s.lk);
	endfunction

	function automatic regspec_t write_target(fetch_slot_t s);
		if (s.back_branch && s.lk)
			return regspec_t'(`LR0);
		return s.tgt;
	endfunction

	// ==============================
	// shadow model
	// ==============================

	// acceptance follows the enqueue rule on the shadow queue before the edge
	assign exp_take0 = !branchmiss && slot0.v && !sq_v[s_tail];
	assign exp_take1 = exp_take0 && !slot0.back_branch && slot1.v &&
		!sq_v[s_tail + qtag_t'(1)];
	assign exp_lone = !branchmiss && !slot0.v && slot1.v && !sq_v[s_tail];
	assign exp_count = {1'b0, exp_take0} + {1'b0, exp_take1} + {1'b0, exp_lone};

	always @(posedge clk or posedge rst) begin : model
		logic [`QENTRIES-1:0] v;
		logic [`QENTRIES-1:0] rfw;
		regspec_t [`QENTRIES-1:0] tgt;
		qtag_t [`AREGS-1:0] src;
		logic [`AREGS-1:0] rv;
		logic [`AREGS-1:0] live;
		logic [`QENTRIES-1:0] flushed;
		fetch_slot_t [1:0] s;
		logic [1:0] take;
		qtag_t head;
		qtag_t tail;
		qtag_t start;
		logic ret;
		regspec_t d;
		if (rst) begin
			sq_v <= '0;
			sq_rfw <= '0;
			sq_tgt <= '0;
			s_head <= '0;
			s_tail <= '0;
			s_src <= '0;
			exp_rf_v <= '1;
			exp_state <= EMPTY;
		end else begin
			v = sq_v;
			rfw = sq_rfw;
			tgt = sq_tgt;
			src = s_src;
			rv = exp_rf_v;
			head = s_head;
			tail = s_tail;
			live = '0;
			flushed = '0;
			start = miss_id + qtag_t'(1);
			// walk from the entry after the missed branch up to the tail
			if (branchmiss) begin
				for (qtag_t t = start; t != tail; t++)
					flushed[t] = v[t];
			end
			for (int i = 0; i < `QENTRIES; i++) begin
				if (v[i] && rfw[i] && !flushed[i])
					live[tgt[i]] = 1'b1;
			end
			if (branchmiss) begin
				for (int n = 1; n < `AREGS; n++) begin
					if (!live[n])
						rv[n] = 1'b1;
				end
			end
			// the queue's newest-writer flag is the same as the table naming the entry,
			// so one comparison covers both ways a commit can finalize its register
			ret = commit_en;
			for (int k = 0; k < 2; k++) begin
				ret = ret && v[head] && !flushed[head];
				if (ret) begin
					if (rfw[head] && !exp_rf_v[tgt[head]])
						rv[tgt[head]] = (src[tgt[head]] == head);
					v[head] = 1'b0;
					head = head + qtag_t'(1);
				end
			end
			v = v & ~flushed;
			if (branchmiss)
				tail = start;
			// how many slots went in is taken from the DUT
			// a lone slot1 counts as slot1
			s[0] = slot0;
			s[1] = slot1;
			take[0] = slot0.v && (enq_count != 2'd0);
			take[1] = slot0.v ? (enq_count == 2'd2) : (enq_count == 2'd1);
			for (int k = 0; k < 2; k++) begin
				if (take[k]) begin
					d = write_target(s[k]);
					v[tail] = 1'b1;
					rfw[tail] = is_writer(s[k]);
					tgt[tail] = d;
					if (is_writer(s[k])) begin
						src[d] = tail;
						rv[d] = 1'b0;
					end
					tail = tail + qtag_t'(1);
				end
			end
			rv[0] = 1'b1;
			sq_v <= v;
			sq_rfw <= rfw;
			sq_tgt <= tgt;
			s_head <= head;
			s_tail <= tail;
			s_src <= src;
			exp_rf_v <= rv;
			if (v == '0)
				exp_state <= EMPTY;
			else if (v == '1)
				exp_state <= FULL;
			else
				exp_state <= PARTIAL;
		end
	end

	// ==============================
	// checks
	// ==============================

	rf_v_matches: assert property (@(posedge clk) disable iff (rst) rf_v == exp_rf_v)
		else begin
			error_count++;
			$display("Fail time %0t: rf_v expected %h, got %h", $time, exp_rf_v, rf_v);
		end

	enq_count_matches: assert property (@(posedge clk) disable iff (rst) enq_count == exp_count)
		else begin
			error_count++;
			$display("Fail time %0t: enq_count expected %0d, got %0d", $time, exp_count, enq_count);
		end

	iq_state_matches: assert property (@(posedge clk) disable iff (rst) iq_state == exp_state)
		else begin
			error_count++;
			$display("Fail time %0t: iq_state expected %0d, got %0d", $time, exp_state, iq_state);
		end

	r0_always_valid: assert property (@(posedge clk) disable iff (rst) rf_v[0])
		else begin
			error_count++;
			$display("Fail time %0t: rf_v[0] expected 1, got 0", $time);
		end

	// ==============================
	// stimulus helpers
	// ==============================

	function automatic fetch_slot_t build_slot(logic rfw, regspec_t tgt, logic bb, logic lk);
		fetch_slot_t s;
		s.v = 1'b1;
		s.rfw = rfw;
		s.tgt = tgt;
		s.back_branch = bb;
		s.lk = lk;
		return s;
	endfunction

	// targets stay clear of r0 and of the link register
	function automatic regspec_t random_reg();
		return regspec_t'(1 + ($urandom % 55));
	endfunction

	function automatic regspec_t next_reg(regspec_t r);
		return (r == regspec_t'(55)) ? regspec_t'(1) : r + regspec_t'(1);
	endfunction

	task automatic drive_idle();
		slot0 = '0;
		slot1 = '0;
		commit_en = 1'b0;
		branchmiss = 1'b0;
		miss_id = '0;
	endtask

	task automatic idle_cycles(int n);
		drive_idle();
		repeat (n) @(negedge clk);
	endtask

	task automatic offer(fetch_slot_t a, fetch_slot_t b);
		drive_idle();
		slot0 = a;
		slot1 = b;
		@(negedge clk);
	endtask

	task automatic commit_cycle();
		drive_idle();
		commit_en = 1'b1;
		@(negedge clk);
	endtask

	task automatic finish_test(int num, string name, int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			tests_passed++;
			$display("test %0d %s: passed", num, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", num, name, error_count - errors_before);
		end
	endtask

	// ==============================
	// sequences
	// ==============================

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the sequences did not finish",
			WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : main
		int start;
		regspec_t r;
		regspec_t ra;
		regspec_t rb;
		regspec_t rc;
		qtag_t branch_tag;
		fetch_slot_t a;
		rst = 1'b1;
		drive_idle();
		void'($urandom(32'h8400_a501));
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// everything final and nothing taken with empty slots
		start = error_count;
		idle_cycles(4);
		finish_test(1, "reset state", start);

		start = error_count;
		r = random_reg();
		offer(build_slot(1'b1, r, 1'b0, 1'b0), '0);
		idle_cycles(2);
		commit_cycle();
		idle_cycles(2);
		finish_test(2, "single write and commit", start);

		// an unrelated writer goes first so the first commit takes only the older of the pair
		start = error_count;
		r = random_reg();
		offer(build_slot(1'b1, next_reg(r), 1'b0, 1'b0), '0);
		offer(build_slot(1'b1, r, 1'b0, 1'b0), build_slot(1'b1, r, 1'b0, 1'b0));
		idle_cycles(1 + ($urandom % 3));
		commit_cycle();
		idle_cycles(1);
		commit_cycle();
		idle_cycles(1);
		// the older writer retires while the younger one is being queued
		r = random_reg();
		offer(build_slot(1'b1, r, 1'b0, 1'b0), '0);
		drive_idle();
		slot0 = build_slot(1'b1, r, 1'b0, 1'b0);
		commit_en = 1'b1;
		@(negedge clk);
		idle_cycles(1 + ($urandom % 3));
		commit_cycle();
		idle_cycles(1);
		// a linking back branch ends the group so slot1 is offered again alone
		r = random_reg();
		offer(build_slot(1'b0, '0, 1'b1, 1'b1), build_slot(1'b1, r, 1'b0, 1'b0));
		offer(build_slot(1'b1, r, 1'b0, 1'b0), '0);
		idle_cycles(1);
		commit_cycle();
		idle_cycles(2);
		finish_test(3, "same target and link branch", start);

		// five pairs against eight entries leave the last pair facing a full queue
		start = error_count;
		for (int k = 0; k < 5; k++) begin
			if (k == 1)
				a = build_slot(1'b1, '0, 1'b0, 1'b0);
			else
				a = build_slot(1'b1, random_reg(), 1'b0, 1'b0);
			offer(a, build_slot(1'b1, random_reg(), 1'b0, 1'b0));
		end
		idle_cycles(1);
		for (int k = 0; k < 4; k++) begin
			commit_cycle();
			idle_cycles($urandom % 3);
		end
		idle_cycles(1);
		finish_test(4, "full queue and r0", start);

		// E0 survives, E1 is the missed branch, E2 to E4 are squashed
		start = error_count;
		ra = random_reg();
		rb = next_reg(ra);
		rc = next_reg(rb);
		branch_tag = s_tail + qtag_t'(1);
		offer(build_slot(1'b1, ra, 1'b0, 1'b0), build_slot(1'b0, '0, 1'b0, 1'b0));
		offer(build_slot(1'b1, rb, 1'b0, 1'b0), build_slot(1'b1, rb, 1'b0, 1'b0));
		offer(build_slot(1'b1, rc, 1'b0, 1'b0), '0);
		idle_cycles(1);
		drive_idle();
		branchmiss = 1'b1;
		miss_id = branch_tag;
		@(negedge clk);
		idle_cycles(2);
		commit_cycle();
		idle_cycles(2);
		finish_test(5, "branch miss recovery", start);

		$display("tests run %0d, passed %0d, failed %0d, check errors %0d",
			tests_run, tests_passed, tests_run - tests_passed, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/regstat_pkg.sv
hw/issue_queue.sv
hw/regfile_source.sv
hw/regfile_valid.sv
hw/regstat_top.sv
testbench/tb_regstat.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_regstat \
	-f filelist.f \
	-o sim_regstat

./obj_dir/sim_regstat > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "run failed, see sim.log"
	exit 1
fi

echo "run finished, see sim.log"
